/* build.f */
+incdir+verilog
verilog/copy_pkg.sv
verilog/context_regs.sv
verilog/read_requester.sv
verilog/line_fifo.sv
verilog/write_requester.sv
verilog/copy_engine.sv
tests/copy_engine_asserts.sv
tests/copy_engine_tb.sv

/* Makefile */
VERILATOR  = verilator
TOP        = copy_engine_tb
FILELIST   = build.f
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
RUN_FLAGS  = +verilator+error+limit+1000
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = SOME TESTS FAILED
PASS_MSG   = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/copy_engine_tb.sv */
// --------------------
// copy engine testbench, memory model, stimulus and result checks
// --------------------
`timescale 1ns/100ps
`include "copy_params.svh"

module copy_engine_tb;

  localparam int TOTAL_LINES    = 5 + 37 + 0 + 20;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_LINES + 2000;

  logic                   clk = 1'b0;
  logic                   reset = 1'b1;
  logic                   start = 1'b0;
  copy_pkg::afu_context_t afu_context = '0;
  copy_pkg::line_addr_t   rd_req_addr;
  logic                   rd_req_en;
  logic                   rd_req_almostfull = 1'b0;
  logic                   rd_rsp_valid = 1'b0;
  copy_pkg::cl_data_t     rd_rsp_data = '0;
  copy_pkg::line_addr_t   wr_req_addr;
  copy_pkg::cl_data_t     wr_req_data;
  logic                   wr_req_en;
  logic                   wr_req_almostfull = 1'b0;
  logic                   done;

  logic [31:0]            rng_state = 32'h30b7_58e0;
  copy_pkg::line_addr_t   addr_q[$];
  copy_pkg::line_addr_t   run_src = '0;
  copy_pkg::line_addr_t   run_dest = '0;
  int                     run_count = 0;
  int                     rd_count = 0;
  int                     wr_count = 0;
  int                     done_delay = 0;
  logic                   check_done = 1'b0;
  logic                   reset_seen = 1'b0;
  logic                   rd_af_prev = 1'b0;
  logic                   wr_af_prev = 1'b0;
  int                     addr_errors = 0;
  int                     data_errors = 0;
  int                     level_errors = 0;
  int                     other_errors = 0;
  int                     run_errors = 0;
  int                     total_errors = 0;
  int                     cycle_count = 0;

  copy_engine copy_engine_inst (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .afu_context       (afu_context),
    .rd_req_addr       (rd_req_addr),
    .rd_req_en         (rd_req_en),
    .rd_req_almostfull (rd_req_almostfull),
    .rd_rsp_valid      (rd_rsp_valid),
    .rd_rsp_data       (rd_rsp_data),
    .wr_req_addr       (wr_req_addr),
    .wr_req_data       (wr_req_data),
    .wr_req_en         (wr_req_en),
    .wr_req_almostfull (wr_req_almostfull),
    .done              (done)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // reference line contents, a chain of LCG steps seeded by the line address
  function automatic copy_pkg::cl_data_t line_pattern(input copy_pkg::line_addr_t addr);
    logic [31:0]        s;
    copy_pkg::cl_data_t d;
    int                 i;
    s = addr[31:0] ^ 32'(addr >> 32);
    d = '0;
    for (i = 0; i < `CL_WIDTH / 32; i++) begin
      s = lcg_next(s);
      d[i*32 +: 32] = s;
    end
    return d;
  endfunction

  task automatic check_addr(input string name, input copy_pkg::line_addr_t got,
                            input copy_pkg::line_addr_t exp);
    if (got !== exp) begin
      addr_errors = addr_errors + 1;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_line(input string name, input copy_pkg::cl_data_t got,
                            input copy_pkg::cl_data_t exp);
    if (got !== exp) begin
      data_errors = data_errors + 1;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      level_errors = level_errors + 1;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  // memory model and random back-pressure on both request ports
  always @(posedge clk) begin
    if (reset) begin
      rd_rsp_valid      <= 1'b0;
      rd_req_almostfull <= 1'b0;
      wr_req_almostfull <= 1'b0;
    end else begin
      rng_state = lcg_next(rng_state);
      if (rng_state[31:29] == 3'd0) begin
        rd_req_almostfull <= !rd_req_almostfull;
      end
      if (rng_state[28:26] == 3'd0) begin
        wr_req_almostfull <= !wr_req_almostfull;
      end
      // responses leave in request order, with random gaps
      rd_rsp_valid <= 1'b0;
      if (addr_q.size() > 0 && rng_state[25]) begin
        rd_rsp_valid <= 1'b1;
        rd_rsp_data  <= line_pattern(addr_q.pop_front());
      end
      if (rd_req_en) begin
        addr_q.push_back(rd_req_addr);
      end
    end
  end

  // compare process, follows every request and write of a run
  always @(posedge clk) begin
    if (reset) begin
      reset_seen = 1'b1;
    end else begin
      if (reset_seen) begin
        reset_seen = 1'b0;
        check_level("rd_req_en", rd_req_en, 1'b0);
        check_level("wr_req_en", wr_req_en, 1'b0);
        check_level("done", done, 1'b0);
      end
      // a new context, addresses aligned to whole lines
      if (start) begin
        run_src    = copy_pkg::line_addr_t'(afu_context[`CTX_SRC_LSB +: 64] >> `CL_OFFSET_BITS);
        run_dest   = copy_pkg::line_addr_t'(afu_context[`CTX_DEST_LSB +: 64] >> `CL_OFFSET_BITS);
        run_count  = int'(afu_context[`CTX_COUNT_LSB +: `COUNT_WIDTH]);
        rd_count   = 0;
        wr_count   = 0;
        check_done = 1'b0;
        done_delay = 2;
      end else if (done_delay > 0) begin
        done_delay = done_delay - 1;
        check_done = (done_delay == 0);
      end
      if (check_done) begin
        check_level("done", done, wr_count == run_count);
      end
      if (rd_af_prev) begin
        check_level("rd_req_en", rd_req_en, 1'b0);
      end
      if (wr_af_prev) begin
        check_level("wr_req_en", wr_req_en, 1'b0);
      end
      if (rd_req_en) begin
        if (rd_count >= run_count) begin
          other_errors = other_errors + 1;
          $display("read request at %h lies outside the source region", rd_req_addr);
        end else begin
          check_addr("rd_req_addr", rd_req_addr, run_src + copy_pkg::line_addr_t'(rd_count));
        end
        rd_count = rd_count + 1;
      end
      if (wr_req_en) begin
        if (wr_count >= run_count) begin
          other_errors = other_errors + 1;
          $display("write to %h comes after the last line of the run", wr_req_addr);
        end else begin
          check_addr("wr_req_addr", wr_req_addr, run_dest + copy_pkg::line_addr_t'(wr_count));
          check_line("wr_req_data", wr_req_data,
                     line_pattern(run_src + copy_pkg::line_addr_t'(wr_count)));
        end
        wr_count = wr_count + 1;
      end
      if (rd_count - wr_count > `CHUNK_LINES) begin
        other_errors = other_errors + 1;
        $display("%0d lines requested but not yet written, more than one pass",
                 rd_count - wr_count);
      end
      rd_af_prev = rd_req_almostfull;
      wr_af_prev = wr_req_almostfull;
    end
  end

  // one copy from start to done
  task automatic run_copy(input logic [63:0] src_byte, input logic [63:0] dest_byte,
                          input int lines);
    copy_pkg::afu_context_t ctx;
    ctx = {8{64'h5a5a_a5a5_0f0f_f0f0}};
    ctx[`CTX_SRC_LSB +: 64] = src_byte;
    ctx[`CTX_DEST_LSB +: 64] = dest_byte;
    ctx[`CTX_COUNT_LSB +: `COUNT_WIDTH] = `COUNT_WIDTH'(lines);
    @(posedge clk);
    start       <= 1'b1;
    afu_context <= ctx;
    @(posedge clk);
    start <= 1'b0;
    repeat (2) @(posedge clk);
    while (done !== 1'b1) begin
      @(posedge clk);
    end
    if (rd_count != lines) begin
      run_errors = run_errors + 1;
      $display("run of %0d lines issued %0d read requests", lines, rd_count);
    end
    if (wr_count != lines) begin
      run_errors = run_errors + 1;
      $display("run of %0d lines issued %0d write requests", lines, wr_count);
    end
    repeat (8) @(posedge clk);
  endtask

  initial begin
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);
    run_copy(64'h0000_0000_1000_0000, 64'h0000_0000_2000_0040, 5);
    // unaligned byte addresses, three passes
    run_copy(64'h0000_0012_3456_7f95, 64'h0000_00ab_cdef_0123, 37);
    run_copy(64'h0000_0000_0000_4000, 64'h0000_0000_0000_8000, 0);
    run_copy(64'h0000_0000_7fff_ffc0, 64'h0000_0001_0000_0000, 20);
    total_errors = addr_errors + data_errors + level_errors + other_errors + run_errors;
    $display("errors: address %0d, data %0d, level %0d, other %0d, run %0d",
             addr_errors, data_errors, level_errors, other_errors, run_errors);
    if (total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // run limit from the total number of lines
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

endmodule

/* tests/copy_engine_asserts.sv */
// --------------------
// copy engine assertions on back-pressure and done
// --------------------
`timescale 1ns/100ps

module copy_engine_asserts (
  input logic clk,
  input logic reset,
  input logic start,
  input logic rd_req_almostfull,
  input logic rd_req_en,
  input logic wr_req_almostfull,
  input logic wr_req_en,
  input logic done
);

  // no read request in the cycle after almost-full
  rd_backpressure: assert property (@(posedge clk) disable iff (reset)
    rd_req_almostfull |=> !rd_req_en)
    else $error("rd_req_en high in the cycle after rd_req_almostfull");

  // same rule on the write side
  wr_backpressure: assert property (@(posedge clk) disable iff (reset)
    wr_req_almostfull |=> !wr_req_en)
    else $error("wr_req_en high in the cycle after wr_req_almostfull");

  // done only drops two cycles after an accepted start
  done_hold: assert property (@(posedge clk) disable iff (reset)
    $fell(done) |-> $past(start, 2))
    else $error("done fell without a start");

endmodule

bind copy_engine copy_engine_asserts copy_engine_asserts_inst (
  .clk               (clk),
  .reset             (reset),
  .start             (start),
  .rd_req_almostfull (rd_req_almostfull),
  .rd_req_en         (rd_req_en),
  .wr_req_almostfull (wr_req_almostfull),
  .wr_req_en         (wr_req_en),
  .done              (done)
);

/* verilog/copy_engine.sv */
// --------------------
// cache-line copy engine top level
// --------------------
`timescale 1ns/100ps

module copy_engine (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  copy_pkg::afu_context_t afu_context,
  output copy_pkg::line_addr_t   rd_req_addr,
  output logic                   rd_req_en,
  input  logic                   rd_req_almostfull,
  input  logic                   rd_rsp_valid,
  input  copy_pkg::cl_data_t     rd_rsp_data,
  output copy_pkg::line_addr_t   wr_req_addr,
  output copy_pkg::cl_data_t     wr_req_data,
  output logic                   wr_req_en,
  input  logic                   wr_req_almostfull,
  output logic                   done
);

  copy_pkg::line_addr_t  src_line;
  copy_pkg::line_addr_t  dest_line;
  copy_pkg::line_count_t num_lines;
  logic                  active;
  logic                  go;
  logic                  finished;
  logic                  fill_en;
  copy_pkg::cl_data_t    fill_data;
  logic                  pop;
  copy_pkg::cl_data_t    pop_data;
  logic                  fifo_empty;

  // response capture, one cycle before the buffer
  always_ff @(posedge clk) begin
    if (reset) begin
      fill_en <= 1'b0;
    end else begin
      fill_en <= rd_rsp_valid;
    end
  end

  always_ff @(posedge clk) begin
    fill_data <= rd_rsp_data;
  end

  context_regs context_regs_inst (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .afu_context (afu_context),
    .finished    (finished),
    .src_line    (src_line),
    .dest_line   (dest_line),
    .num_lines   (num_lines),
    .active      (active),
    .go          (go)
  );

  read_requester read_requester_inst (
    .clk               (clk),
    .reset             (reset),
    .go                (go),
    .src_line          (src_line),
    .num_lines         (num_lines),
    .rd_req_almostfull (rd_req_almostfull),
    .fill_en           (fill_en),
    .fifo_empty        (fifo_empty),
    .rd_req_addr       (rd_req_addr),
    .rd_req_en         (rd_req_en)
  );

  // pass gating keeps the buffer from overflowing, full is not needed here
  line_fifo line_fifo_inst (
    .clk       (clk),
    .reset     (reset),
    .push      (fill_en && active),
    .push_data (fill_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (fifo_empty),
    .full      ()
  );

  write_requester write_requester_inst (
    .clk               (clk),
    .reset             (reset),
    .go                (go),
    .dest_line         (dest_line),
    .num_lines         (num_lines),
    .fifo_empty        (fifo_empty),
    .wr_req_almostfull (wr_req_almostfull),
    .pop_data          (pop_data),
    .pop               (pop),
    .wr_req_addr       (wr_req_addr),
    .wr_req_data       (wr_req_data),
    .wr_req_en         (wr_req_en),
    .done              (done),
    .finished          (finished)
  );

endmodule

/* verilog/write_requester.sv */
// --------------------
// write request path, drains the buffer to the destination
// --------------------
`timescale 1ns/100ps

module write_requester (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  go,
  input  copy_pkg::line_addr_t  dest_line,
  input  copy_pkg::line_count_t num_lines,
  input  logic                  fifo_empty,
  input  logic                  wr_req_almostfull,
  input  copy_pkg::cl_data_t    pop_data,
  output logic                  pop,
  output copy_pkg::line_addr_t  wr_req_addr,
  output copy_pkg::cl_data_t    wr_req_data,
  output logic                  wr_req_en,
  output logic                  done,
  output logic                  finished
);

  copy_pkg::line_addr_t  next_addr;
  copy_pkg::line_count_t written;

  // drain whenever a line waits and the write side has room
  assign pop = !fifo_empty && !wr_req_almostfull;

  // FIFO read register lines up with wr_req_en
  assign wr_req_data = pop_data;

  // run is over once the last line is written
  assign finished = done;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_req_en <= 1'b0;
      done      <= 1'b0;
      written   <= '0;
    end else begin
      wr_req_en <= pop;
      if (go) begin
        written <= '0;
        done    <= (num_lines == '0);
      end else if (wr_req_en) begin
        written <= written + 1'b1;
        if (written + 1'b1 == num_lines) begin
          done <= 1'b1;
        end
      end
    end
  end

  // incrementing destination address
  always_ff @(posedge clk) begin
    if (go) begin
      next_addr <= dest_line;
    end else if (pop) begin
      wr_req_addr <= next_addr;
      next_addr   <= next_addr + 1'b1;
    end
  end

endmodule

/* verilog/line_fifo.sv */
// --------------------
// line buffer FIFO, registered read data
// --------------------
`timescale 1ns/100ps
`include "copy_params.svh"

module line_fifo #(
  parameter int DEPTH_BITS = `FIFO_DEPTH_BITS
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               push,
  input  copy_pkg::cl_data_t push_data,
  input  logic               pop,
  output copy_pkg::cl_data_t pop_data,
  output logic               empty,
  output logic               full
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  copy_pkg::cl_data_t  mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   count;
  logic                  do_push;
  logic                  do_pop;

  assign empty   = (count == '0);
  assign full    = (count == (DEPTH_BITS + 1)'(DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // storage and output register
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
    if (do_pop) begin
      pop_data <= mem[rd_ptr];
    end
  end

  // pointers wrap at the power of two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* verilog/read_requester.sv */
// --------------------
// read request sequencer, issues the source region pass by pass
// --------------------
`timescale 1ns/100ps
`include "copy_params.svh"

module read_requester (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  go,
  input  copy_pkg::line_addr_t  src_line,
  input  copy_pkg::line_count_t num_lines,
  input  logic                  rd_req_almostfull,
  input  logic                  fill_en,
  input  logic                  fifo_empty,
  output copy_pkg::line_addr_t  rd_req_addr,
  output logic                  rd_req_en
);

  localparam int PASS_W = $clog2(`CHUNK_LINES) + 1;

  typedef enum logic [1:0] {
    st_idle,
    st_wait_vacant,
    st_issue
  } state_t;

  state_t                state;
  copy_pkg::line_addr_t  next_addr;
  copy_pkg::line_count_t issued;
  copy_pkg::line_count_t returned;
  logic [PASS_W-1:0]     pass_cnt;

  // go starts the first pass at once, the buffer is known empty then
  copy_pkg::line_addr_t  base_addr;
  copy_pkg::line_count_t base_issued;
  logic [PASS_W-1:0]     base_pass;
  logic                  in_issue;
  logic                  region_end;
  logic                  pass_end;
  logic                  can_issue;
  logic                  vacant;

  assign base_addr   = go ? src_line : next_addr;
  assign base_issued = go ? '0 : issued;
  assign base_pass   = go ? '0 : pass_cnt;
  assign in_issue    = go || (state == st_issue);
  assign region_end  = (base_issued == num_lines);
  assign pass_end    = region_end || (base_pass == PASS_W'(`CHUNK_LINES));
  assign can_issue   = in_issue && !pass_end && !rd_req_almostfull;

  // every request back and written out of the buffer
  assign vacant = (returned == issued) && fifo_empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      rd_req_en <= 1'b0;
      issued    <= '0;
      returned  <= '0;
      pass_cnt  <= '0;
    end else begin
      rd_req_en <= can_issue;

      if (go) begin
        returned <= '0;
      end else if (fill_en) begin
        returned <= returned + 1'b1;
      end

      if (go) begin
        issued   <= '0;
        pass_cnt <= '0;
      end
      if (can_issue) begin
        issued   <= base_issued + 1'b1;
        pass_cnt <= base_pass + 1'b1;
      end

      case (state)
        st_idle: begin
          if (go && num_lines != '0) begin
            state <= st_issue;
          end
        end
        st_issue: begin
          if (pass_end) begin
            state <= region_end ? st_idle : st_wait_vacant;
          end
        end
        st_wait_vacant: begin
          if (vacant) begin
            state    <= st_issue;
            pass_cnt <= '0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // sequential source addresses
  always_ff @(posedge clk) begin
    if (go) begin
      next_addr <= src_line;
    end
    if (can_issue) begin
      rd_req_addr <= base_addr;
      next_addr   <= base_addr + 1'b1;
    end
  end

endmodule

/* verilog/context_regs.sv */
// --------------------
// context registers, latch the run fields on start
// --------------------
`timescale 1ns/100ps
`include "copy_params.svh"

module context_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  copy_pkg::afu_context_t afu_context,
  input  logic                   finished,
  output copy_pkg::line_addr_t   src_line,
  output copy_pkg::line_addr_t   dest_line,
  output copy_pkg::line_count_t  num_lines,
  output logic                   active,
  output logic                   go
);

  logic accept;

  // a start during a run is dropped
  assign accept = start && !active;

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      go     <= 1'b0;
    end else begin
      go <= accept;
      if (accept) begin
        active <= 1'b1;
      end else if (finished && !go) begin
        // finished is still the old run's level while go is high
        active <= 1'b0;
      end
    end
  end

  // byte addresses lose the offset bits to become line addresses
  always_ff @(posedge clk) begin
    if (accept) begin
      src_line  <= afu_context[`CTX_SRC_LSB + `CL_OFFSET_BITS + `LINE_ADDR_WIDTH - 1 :
                               `CTX_SRC_LSB + `CL_OFFSET_BITS];
      dest_line <= afu_context[`CTX_DEST_LSB + `CL_OFFSET_BITS + `LINE_ADDR_WIDTH - 1 :
                               `CTX_DEST_LSB + `CL_OFFSET_BITS];
      num_lines <= afu_context[`CTX_COUNT_LSB + `COUNT_WIDTH - 1 : `CTX_COUNT_LSB];
    end
  end

endmodule

/* verilog/copy_pkg.sv */
// --------------------
// shared types of the cache-line copy engine
// --------------------
`include "copy_params.svh"

package copy_pkg;

  // one cache line of payload
  typedef logic [`CL_WIDTH-1:0] cl_data_t;

  // address in units of whole cache lines
  typedef logic [`LINE_ADDR_WIDTH-1:0] line_addr_t;

  // number of lines in a region
  typedef logic [`COUNT_WIDTH-1:0] line_count_t;

  // context word from software, one line wide
  //   [127:64]  source byte address
  //   [191:128] destination byte address
  //   [223:192] line count
  typedef logic [`CL_WIDTH-1:0] afu_context_t;

endpackage

/* verilog/copy_params.svh */
// --------------------
// copy engine widths, pass size, buffer depth and context layout
// --------------------
`ifndef COPY_PARAMS_SVH
`define COPY_PARAMS_SVH

// cache line and address widths
`define CL_WIDTH        512
`define LINE_ADDR_WIDTH 58
`define COUNT_WIDTH     32
`define CL_OFFSET_BITS  6

// most lines requested in one pass, buffer must hold a full pass
`define CHUNK_LINES     16
`define FIFO_DEPTH_BITS 4

// bit offsets of the fields inside the context word
`define CTX_SRC_LSB     64
`define CTX_DEST_LSB    128
`define CTX_COUNT_LSB   192

`endif
